// ==== hdl/joy_reg_pkg.sv ====
`default_nettype none

package joy_reg_pkg;

	// CPU access width as presented on the bus
	typedef enum logic [1:0] {
		ACCESS_8BIT  = 2'd0,
		ACCESS_16BIT = 2'd1,
		ACCESS_32BIT = 2'd2,
		ACCESS_UNDEF = 2'd3
	} access_width_e;

	// ----------------------------------------
	// Halfword slots, byte offset / 2
	// ----------------------------------------
	localparam logic [2:0] REG_TX_RX_DATA = 3'd0;
	localparam logic [2:0] REG_STAT       = 3'd2;
	localparam logic [2:0] REG_MODE       = 3'd4;
	localparam logic [2:0] REG_CTRL       = 3'd5;
	localparam logic [2:0] REG_BAUD       = 3'd7;

	// CTRL bit positions
	localparam int CTRL_TXEN           = 0;
	localparam int CTRL_SELECT         = 1;
	localparam int CTRL_RXEN           = 2;
	localparam int CTRL_ACK_CMD        = 4;
	localparam int CTRL_RESET_CMD      = 6;
	localparam int CTRL_RX_INT_MODE_LO = 8;
	localparam int CTRL_RX_INT_MODE_HI = 9;
	localparam int CTRL_TX_INT_EN      = 10;
	localparam int CTRL_RX_INT_EN      = 11;
	localparam int CTRL_ACK_INT_EN     = 12;
	localparam int CTRL_SLOT           = 13;

	// Bits 0..13 minus RXEN and both commands
	localparam logic [15:0] CTRL_RW_MASK = 16'h3FFF & ~((16'd1 << CTRL_RXEN) |
		(16'd1 << CTRL_ACK_CMD) | (16'd1 << CTRL_RESET_CMD));
	// Factor, length, parity enable and type, clock polarity
	localparam logic [15:0] MODE_RW_MASK = 16'h013F;

	// STAT bit positions in the 32-bit word
	localparam int STAT_TX_READY    = 0;
	localparam int STAT_RX_PENDING  = 1;
	localparam int STAT_TX_FINISHED = 2;
	localparam int STAT_PARITY_ERR  = 3;
	localparam int STAT_ACK_LEVEL   = 7;
	localparam int STAT_IRQ         = 9;
	localparam int STAT_BAUD_LO     = 11;
	localparam int STAT_BAUD_HI     = 31;

	// ----------------------------------------
	// Write halfword, seen as MODE or CTRL
	// ----------------------------------------
	typedef union packed {
		struct packed {
			logic [6:0] rsvd_hi;
			logic       clk_inv;
			logic [1:0] rsvd_lo;
			logic       parity_odd;
			logic       parity_en;
			logic [1:0] char_len;
			logic [1:0] reload_factor;
		} mode;
		struct packed {
			logic [1:0] rsvd;
			logic       slot;
			logic       ack_int_en;
			logic       rx_int_en;
			logic       tx_int_en;
			logic [1:0] rx_int_mode;
			logic       bit7;
			logic       reset_cmd;
			logic       bit5;
			logic       ack_cmd;
			logic       bit3;
			logic       rxen;
			logic       select;
			logic       txen;
		} ctrl;
	} joy_cfg_word_u;

endpackage

`default_nettype wire

// ==== hdl/joy_link_pkg.sv ====
`default_nettype none

package joy_link_pkg;

	// Peripheral type behind the active select
	typedef enum logic [1:0] {
		DEV_NONE       = 2'd0,
		DEV_CONTROLLER = 2'd1,
		DEV_MEMCARD    = 2'd2
	} device_e;

	// First byte after select picks the device
	localparam logic [7:0] SEL_CONTROLLER = 8'h01;
	localparam logic [7:0] SEL_MEMCARD    = 8'h81;
	// Line floats high when nobody answers
	localparam logic [7:0] NO_REPLY       = 8'hFF;

	// Receive FIFO sizing
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_CNT_W = 4;

	// Two baud ticks per bit, 8 bits
	localparam int XFER_TICKS   = 16;
	localparam int BAUD_TIMER_W = 21;

endpackage

`default_nettype wire

// ==== hdl/joy_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module joy_regs (
	input  logic                                i_clk,
	input  logic                                resetACK,
	// CPU bus
	input  logic                                i_cs,
	input  joy_reg_pkg::access_width_e          i_format,
	input  logic [3:0]                          i_addr,
	input  logic                                i_write,
	input  logic                                i_read,
	input  logic [31:0]                         i_data_in,
	output logic [31:0]                         o_data_out,
	input  logic                                i_ack_n,
	// Baud timer
	output logic [15:0]                         o_baud_reload,
	output logic [1:0]                          o_baud_factor,
	output logic                                o_baud_load,
	input  logic [joy_link_pkg::BAUD_TIMER_W-1:0] i_baud_count,
	// Transfer engine
	output logic                                o_tx_start,
	output logic [7:0]                          o_tx_byte,
	output logic                                o_select,
	output logic                                o_slot,
	input  logic                                i_tx_busy,
	input  logic                                i_tx_done,
	// Receive FIFO
	output logic                                o_rx_pop,
	input  logic [7:0]                          i_rx_data,
	input  logic [joy_link_pkg::FIFO_CNT_W-1:0] i_rx_count,
	input  logic                                i_rx_empty,
	// Status
	output logic                                o_soft_reset,
	output logic                                o_bad_access,
	output logic                                o_irq
);
	import joy_reg_pkg::*;
	import joy_link_pkg::*;

	// Bus decode
	logic [2:0]            w_slot;
	logic                  w_wr;
	logic                  w_rd;
	joy_cfg_word_u         w_wr_half;
	logic                  w_ack_cmd;
	logic                  w_tx_write;
	logic                  w_bad;
	// Stored registers
	joy_cfg_word_u         r_mode;
	logic [15:0]           r_ctrl;
	logic [15:0]           r_baud;
	logic                  r_baud_load;
	// TX hand-off
	logic [7:0]            r_tx_byte;
	logic                  r_tx_pending;
	logic                  r_txen_at_write;
	logic                  r_tx_finished;
	// Status and interrupt
	logic                  r_irq;
	logic                  r_bad_access;
	logic                  w_irq_set;
	logic [FIFO_CNT_W-1:0] w_rx_thresh;
	logic [31:0]           w_stat;

	assign w_slot    = i_addr[3:1];
	assign w_wr      = i_cs && i_write;
	assign w_rd      = i_cs && i_read;
	assign w_wr_half = i_data_in[15:0];

	// Commands only exist on a CTRL write
	assign w_ack_cmd    = w_wr && (w_slot == REG_CTRL) && w_wr_half.ctrl.ack_cmd;
	assign o_soft_reset = w_wr && (w_slot == REG_CTRL) && w_wr_half.ctrl.reset_cmd;

	// TX data only accepted as a full word with the device selected
	assign w_tx_write = w_wr && (w_slot == REG_TX_RX_DATA) && (i_format == ACCESS_32BIT) &&
		r_ctrl[CTRL_SELECT];

	// Reserved slots, or a byte access off the first byte
	assign w_bad = i_cs && ((w_slot == 3'd1) || (w_slot == 3'd3) ||
		((i_format == ACCESS_8BIT) && (i_addr != 4'd0)));

	// Start once the engine is free, TXEN now or at write time
	assign o_tx_start = r_tx_pending && !i_tx_busy && (r_ctrl[CTRL_TXEN] || r_txen_at_write);
	// Pop in the read cycle, head is sampled on the same edge
	assign o_rx_pop   = w_rd && (w_slot == REG_TX_RX_DATA) && !i_rx_empty;

	// RX interrupt at 1, 2, 4 or 8 entries
	assign w_rx_thresh = FIFO_CNT_W'(1) << r_ctrl[CTRL_RX_INT_MODE_HI:CTRL_RX_INT_MODE_LO];
	assign w_irq_set   = (r_ctrl[CTRL_TX_INT_EN] && i_tx_done) ||
		(r_ctrl[CTRL_RX_INT_EN] && (i_rx_count >= w_rx_thresh)) ||
		(r_ctrl[CTRL_ACK_INT_EN] && !i_ack_n);

	// ----------------------------------------
	// Register writes and sticky status
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (resetACK || o_soft_reset) begin
			r_mode          <= '0;
			r_ctrl          <= '0;
			r_baud          <= '0;
			r_baud_load     <= 1'b0;
			r_tx_pending    <= 1'b0;
			r_txen_at_write <= 1'b0;
			r_tx_finished   <= 1'b0;
			r_irq           <= 1'b0;
			r_bad_access    <= 1'b0;
		end else begin
			// Load strobe lags the BAUD write so the timer sees the new value
			r_baud_load <= w_wr && (w_slot == REG_BAUD);
			if (w_wr && (w_slot == REG_MODE))
				r_mode <= w_wr_half & MODE_RW_MASK;
			if (w_wr && (w_slot == REG_CTRL))
				r_ctrl <= w_wr_half & CTRL_RW_MASK;
			if (w_wr && (w_slot == REG_BAUD))
				r_baud <= w_wr_half;
			if (w_bad)
				r_bad_access <= 1'b1;
			// Finished flag lives until the next start
			if (o_tx_start)
				r_tx_finished <= 1'b0;
			else if (i_tx_done)
				r_tx_finished <= 1'b1;
			// A new write overrides a start in the same cycle
			if (o_tx_start)
				r_tx_pending <= 1'b0;
			if (w_tx_write) begin
				r_tx_pending    <= 1'b1;
				r_txen_at_write <= r_ctrl[CTRL_TXEN];
			end
			// Acknowledge wins over a new request
			if (w_ack_cmd)
				r_irq <= 1'b0;
			else if (w_irq_set)
				r_irq <= 1'b1;
		end
	end

	// Pending byte
	always_ff @(posedge i_clk) begin
		if (w_tx_write)
			r_tx_byte <= i_data_in[7:0];
	end

	// STAT word, parity never checked
	always_comb begin
		w_stat                              = '0;
		w_stat[STAT_TX_READY]               = !r_tx_pending && !i_tx_busy;
		w_stat[STAT_RX_PENDING]             = !i_rx_empty;
		w_stat[STAT_TX_FINISHED]            = r_tx_finished;
		w_stat[STAT_PARITY_ERR]             = 1'b0;
		w_stat[STAT_ACK_LEVEL]              = !i_ack_n;
		w_stat[STAT_IRQ]                    = r_irq;
		w_stat[STAT_BAUD_HI:STAT_BAUD_LO]   = i_baud_count;
	end

	// Registered read mux
	always_ff @(posedge i_clk) begin
		if (w_rd) begin
			case (w_slot)
				REG_TX_RX_DATA: o_data_out <= {24'd0, i_rx_data};
				REG_STAT:       o_data_out <= w_stat;
				REG_MODE:       o_data_out <= {16'd0, r_mode};
				REG_CTRL:       o_data_out <= {16'd0, r_ctrl};
				REG_BAUD:       o_data_out <= {16'd0, r_baud};
				default:        o_data_out <= '0;
			endcase
		end
	end

	assign o_baud_reload = r_baud;
	assign o_baud_factor = r_mode.mode.reload_factor;
	assign o_baud_load   = r_baud_load;
	assign o_tx_byte     = r_tx_byte;
	assign o_select      = r_ctrl[CTRL_SELECT];
	assign o_slot        = r_ctrl[CTRL_SLOT];
	assign o_bad_access  = r_bad_access;
	assign o_irq         = r_irq;

	// Hand-off only to an idle engine
	a_start_idle: assert property (@(posedge i_clk) disable iff (resetACK)
		o_tx_start |-> !i_tx_busy);
	// No pop from an empty FIFO
	a_pop_nonempty: assert property (@(posedge i_clk) disable iff (resetACK)
		o_rx_pop |-> !i_rx_empty);

endmodule

`default_nettype wire

// ==== hdl/joy_baud_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module joy_baud_timer (
	input  logic                                 i_clk,
	input  logic                                 resetACK,
	input  logic                                 i_soft_reset,
	input  logic [15:0]                          i_reload,
	input  logic [1:0]                           i_factor,
	input  logic                                 i_load,
	output logic                                 o_tick,
	output logic [joy_link_pkg::BAUD_TIMER_W-1:0] o_count
);
	import joy_link_pkg::*;

	logic [BAUD_TIMER_W:0]   w_product;
	logic [BAUD_TIMER_W-1:0] w_scaled;
	logic [BAUD_TIMER_W-1:0] r_count;
	// Last value loaded, bound for the count
	logic [BAUD_TIMER_W-1:0] r_limit;
	logic                    w_reload_now;

	// Factor 1, 16 or 64, code 0 is also 1
	always_comb begin
		case (i_factor)
			2'd2:    w_product = {6'd0, i_reload} << 4;
			2'd3:    w_product = {6'd0, i_reload} << 6;
			default: w_product = {6'd0, i_reload};
		endcase
	end

	// Halved, as the timer elapses twice per bit
	assign w_scaled     = w_product[BAUD_TIMER_W:1];
	assign w_reload_now = i_load || (r_count == '0);

	// Free running, also between transfers
	always_ff @(posedge i_clk) begin
		if (resetACK || i_soft_reset) begin
			r_count <= '0;
			r_limit <= '0;
		end else if (w_reload_now) begin
			r_count <= w_scaled;
			r_limit <= w_scaled;
		end else begin
			r_count <= r_count - 1'b1;
		end
	end

	// Zero reload keeps the count at zero, so it ticks every cycle
	assign o_tick  = (r_count == '0);
	assign o_count = r_count;

	a_count_bound: assert property (@(posedge i_clk) disable iff (resetACK)
		o_count <= r_limit);

endmodule

`default_nettype wire

// ==== hdl/joy_xfer.sv ====
`timescale 1ns/10ps
`default_nettype none

module joy_xfer (
	input  logic                  i_clk,
	input  logic                  resetACK,
	input  logic                  i_soft_reset,
	// From the register block
	input  logic                  i_tx_start,
	input  logic [7:0]            i_tx_byte,
	input  logic                  i_select,
	input  logic                  i_slot,
	input  logic                  i_baud_tick,
	// Device side
	input  logic                  i_receive,
	input  logic [7:0]            i_receive_data,
	output logic                  o_emit,
	output logic [7:0]            o_emit_data,
	output joy_link_pkg::device_e o_emit_dev,
	output logic                  o_emit_slot,
	// Status and reply
	output logic                  o_busy,
	output logic                  o_done,
	output logic                  o_rx_push,
	output logic [7:0]            o_rx_byte
);
	import joy_link_pkg::*;

	logic                          r_emit;
	logic [7:0]                    r_emit_data;
	device_e                       r_emit_dev;
	logic                          r_emit_slot;
	device_e                       r_dev;
	logic                          r_busy;
	logic                          r_done;
	logic [$clog2(XFER_TICKS)-1:0] r_tick_cnt;
	logic [7:0]                    r_reply;
	logic                          w_last_tick;

	// Final baud tick of the byte
	assign w_last_tick = r_busy && i_baud_tick &&
		(r_tick_cnt == $bits(r_tick_cnt)'(XFER_TICKS - 1));

	// ----------------------------------------
	// Sequencing and device type
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (resetACK || i_soft_reset) begin
			r_emit     <= 1'b0;
			r_busy     <= 1'b0;
			r_done     <= 1'b0;
			r_tick_cnt <= '0;
			r_dev      <= DEV_NONE;
		end else begin
			r_emit <= i_tx_start;
			r_done <= w_last_tick;
			if (i_tx_start) begin
				r_busy     <= 1'b1;
				r_tick_cnt <= '0;
			end else if (w_last_tick) begin
				r_busy <= 1'b0;
			end else if (r_busy && i_baud_tick) begin
				r_tick_cnt <= r_tick_cnt + 1'b1;
			end
			// Deselect forgets the device
			if (!i_select) begin
				r_dev <= DEV_NONE;
			end else if (i_tx_start && (r_dev == DEV_NONE)) begin
				if (i_tx_byte == SEL_CONTROLLER)
					r_dev <= DEV_CONTROLLER;
				else if (i_tx_byte == SEL_MEMCARD)
					r_dev <= DEV_MEMCARD;
			end
		end
	end

	// Emitted byte carries the type before this byte's update
	always_ff @(posedge i_clk) begin
		if (i_tx_start) begin
			r_emit_data <= i_tx_byte;
			r_emit_dev  <= r_dev;
			r_emit_slot <= i_slot;
			r_reply     <= NO_REPLY;
		end else if (r_busy && i_receive) begin
			r_reply <= i_receive_data;
		end
	end

	assign o_emit      = r_emit;
	assign o_emit_data = r_emit_data;
	assign o_emit_dev  = r_emit_dev;
	assign o_emit_slot = r_emit_slot;
	assign o_busy      = r_busy;
	assign o_done      = r_done;
	// Reply pushed with the done pulse
	assign o_rx_push   = r_done;
	assign o_rx_byte   = r_reply;

	a_emit_single: assert property (@(posedge i_clk) disable iff (resetACK)
		o_emit |=> !o_emit);

endmodule

`default_nettype wire

// ==== hdl/joy_rx_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module joy_rx_fifo (
	input  logic                                i_clk,
	input  logic                                resetACK,
	input  logic                                i_soft_reset,
	input  logic                                i_push,
	input  logic [7:0]                          i_data,
	input  logic                                i_pop,
	output logic [7:0]                          o_data,
	output logic [joy_link_pkg::FIFO_CNT_W-1:0] o_count,
	output logic                                o_empty
);
	import joy_link_pkg::*;

	logic [7:0]                    r_mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] r_wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] r_rd_ptr;
	logic [FIFO_CNT_W-1:0]         r_count;
	logic                          w_do_push;
	logic                          w_do_pop;

	// Full drops the push
	assign w_do_push = i_push && (r_count != FIFO_CNT_W'(FIFO_DEPTH));
	assign w_do_pop  = i_pop && (r_count != '0);

	// Pointers and count
	always_ff @(posedge i_clk) begin
		if (resetACK || i_soft_reset) begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			r_count  <= '0;
		end else begin
			if (w_do_push)
				r_wr_ptr <= r_wr_ptr + 1'b1;
			if (w_do_pop)
				r_rd_ptr <= r_rd_ptr + 1'b1;
			if (w_do_push && !w_do_pop)
				r_count <= r_count + 1'b1;
			else if (w_do_pop && !w_do_push)
				r_count <= r_count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge i_clk) begin
		if (w_do_push)
			r_mem[r_wr_ptr] <= i_data;
	end

	// Head word always visible
	assign o_data  = r_mem[r_rd_ptr];
	assign o_count = r_count;
	assign o_empty = (r_count == '0);

	a_count_max: assert property (@(posedge i_clk) disable iff (resetACK)
		o_count <= FIFO_CNT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== hdl/joy_io_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module joy_io_top (
	input  logic                       i_clk,
	input  logic                       resetACK,
	// CPU side
	input  logic                       i_cs,
	input  joy_reg_pkg::access_width_e i_format,
	input  logic [3:0]                 i_addr,
	input  logic                       i_write,
	input  logic                       i_read,
	input  logic [31:0]                i_data_in,
	output logic [31:0]                o_data_out,
	output logic                       o_irq,
	output logic                       o_bad_access,
	// Device side
	output logic                       o_emit,
	output logic [7:0]                 o_emit_data,
	output joy_link_pkg::device_e      o_emit_dev,
	output logic                       o_emit_slot,
	output logic                       o_select,
	input  logic                       i_receive,
	input  logic [7:0]                 i_receive_data,
	input  logic                       i_ack_n
);
	import joy_link_pkg::*;

	// Baud timer
	logic [15:0]             w_baud_reload;
	logic [1:0]              w_baud_factor;
	logic                    w_baud_load;
	logic                    w_baud_tick;
	logic [BAUD_TIMER_W-1:0] w_baud_count;
	// Transfer engine
	logic                    w_tx_start;
	logic [7:0]              w_tx_byte;
	logic                    w_slot;
	logic                    w_tx_busy;
	logic                    w_tx_done;
	// Receive path
	logic                    w_rx_push;
	logic [7:0]              w_rx_byte;
	logic                    w_rx_pop;
	logic [7:0]              w_rx_data;
	logic [FIFO_CNT_W-1:0]   w_rx_count;
	logic                    w_rx_empty;
	logic                    w_soft_reset;

	joy_regs joy_regs_inst (
		.i_clk         (i_clk),
		.resetACK      (resetACK),
		.i_cs          (i_cs),
		.i_format      (i_format),
		.i_addr        (i_addr),
		.i_write       (i_write),
		.i_read        (i_read),
		.i_data_in     (i_data_in),
		.o_data_out    (o_data_out),
		.i_ack_n       (i_ack_n),
		.o_baud_reload (w_baud_reload),
		.o_baud_factor (w_baud_factor),
		.o_baud_load   (w_baud_load),
		.i_baud_count  (w_baud_count),
		.o_tx_start    (w_tx_start),
		.o_tx_byte     (w_tx_byte),
		.o_select      (o_select),
		.o_slot        (w_slot),
		.i_tx_busy     (w_tx_busy),
		.i_tx_done     (w_tx_done),
		.o_rx_pop      (w_rx_pop),
		.i_rx_data     (w_rx_data),
		.i_rx_count    (w_rx_count),
		.i_rx_empty    (w_rx_empty),
		.o_soft_reset  (w_soft_reset),
		.o_bad_access  (o_bad_access),
		.o_irq         (o_irq)
	);

	joy_baud_timer joy_baud_timer_inst (
		.i_clk        (i_clk),
		.resetACK     (resetACK),
		.i_soft_reset (w_soft_reset),
		.i_reload     (w_baud_reload),
		.i_factor     (w_baud_factor),
		.i_load       (w_baud_load),
		.o_tick       (w_baud_tick),
		.o_count      (w_baud_count)
	);

	// Select level goes out and into the engine
	joy_xfer joy_xfer_inst (
		.i_clk          (i_clk),
		.resetACK       (resetACK),
		.i_soft_reset   (w_soft_reset),
		.i_tx_start     (w_tx_start),
		.i_tx_byte      (w_tx_byte),
		.i_select       (o_select),
		.i_slot         (w_slot),
		.i_baud_tick    (w_baud_tick),
		.i_receive      (i_receive),
		.i_receive_data (i_receive_data),
		.o_emit         (o_emit),
		.o_emit_data    (o_emit_data),
		.o_emit_dev     (o_emit_dev),
		.o_emit_slot    (o_emit_slot),
		.o_busy         (w_tx_busy),
		.o_done         (w_tx_done),
		.o_rx_push      (w_rx_push),
		.o_rx_byte      (w_rx_byte)
	);

	joy_rx_fifo joy_rx_fifo_inst (
		.i_clk        (i_clk),
		.resetACK     (resetACK),
		.i_soft_reset (w_soft_reset),
		.i_push       (w_rx_push),
		.i_data       (w_rx_byte),
		.i_pop        (w_rx_pop),
		.o_data       (w_rx_data),
		.o_count      (w_rx_count),
		.o_empty      (w_rx_empty)
	);

endmodule

`default_nettype wire

// ==== tests/tb_joy_io.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_joy_io;
	import joy_reg_pkg::*;
	import joy_link_pkg::*;

	localparam int POLL_LIMIT     = 200;
	localparam int IRQ_WAIT_LIMIT = 50;
	localparam int REPLY_DELAY    = 3;

	// DUT ports
	logic                    i_clk;
	logic                    resetACK;
	logic                    i_cs;
	access_width_e           i_format;
	logic [3:0]              i_addr;
	logic                    i_write;
	logic                    i_read;
	logic [31:0]             i_data_in;
	logic [31:0]             o_data_out;
	logic                    o_irq;
	logic                    o_bad_access;
	logic                    o_emit;
	logic [7:0]              o_emit_data;
	device_e                 o_emit_dev;
	logic                    o_emit_slot;
	logic                    o_select;
	// Driven only by the device model
	logic                    i_receive = 1'b0;
	logic [7:0]              i_receive_data = 8'h00;
	logic                    i_ack_n;

	// Device model state
	logic [31:0]             lfsr_state = 32'hb3153fff;
	logic [7:0]              model_byte;
	int                      reply_wait = 0;
	int                      emit_count = 0;
	logic [7:0]              replies[$];
	// Expected emit contents
	logic [7:0]              exp_emit_data = 8'h00;
	device_e                 exp_emit_dev = DEV_NONE;
	logic                    exp_emit_slot = 1'b0;
	int                      errors = 0;

	joy_io_top joy_io_top_inst (
		.i_clk          (i_clk),
		.resetACK       (resetACK),
		.i_cs           (i_cs),
		.i_format       (i_format),
		.i_addr         (i_addr),
		.i_write        (i_write),
		.i_read         (i_read),
		.i_data_in      (i_data_in),
		.o_data_out     (o_data_out),
		.o_irq          (o_irq),
		.o_bad_access   (o_bad_access),
		.o_emit         (o_emit),
		.o_emit_data    (o_emit_data),
		.o_emit_dev     (o_emit_dev),
		.o_emit_slot    (o_emit_slot),
		.o_select       (o_select),
		.i_receive      (i_receive),
		.i_receive_data (i_receive_data),
		.i_ack_n        (i_ack_n)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [7:0] random_byte();
		logic [7:0] value;
		logic       fb;
		value = '0;
		for (int i = 0; i < 8; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			value = {value[6:0], lfsr_state[31]};
			lfsr_state = {lfsr_state[30:0], fb};
		end
		return value;
	endfunction

	// ----------------------------------------
	// Device model
	// ----------------------------------------
	always @(posedge i_clk) begin
		i_receive <= 1'b0;
		if (resetACK) begin
			reply_wait <= 0;
		end else if (o_emit) begin
			emit_count <= emit_count + 1;
			reply_wait <= REPLY_DELAY;
		end else if (reply_wait != 0) begin
			reply_wait <= reply_wait - 1;
			// Answer a few cycles after the byte went out
			if (reply_wait == 1) begin
				model_byte = random_byte();
				replies.push_back(model_byte);
				i_receive      <= 1'b1;
				i_receive_data <= model_byte;
			end
		end
	end

	// Emitted byte and device tag
	a_emit_data: assert property (@(posedge i_clk) disable iff (resetACK)
		o_emit |-> (o_emit_data == exp_emit_data)) else begin
		errors++;
		$display("Fail %0t o_emit_data got %h expected %h", $time, o_emit_data, exp_emit_data);
	end
	a_emit_dev: assert property (@(posedge i_clk) disable iff (resetACK)
		o_emit |-> (o_emit_dev == exp_emit_dev)) else begin
		errors++;
		$display("Fail %0t o_emit_dev got %0d expected %0d", $time, o_emit_dev, exp_emit_dev);
	end
	a_emit_slot: assert property (@(posedge i_clk) disable iff (resetACK)
		o_emit |-> (o_emit_slot == exp_emit_slot)) else begin
		errors++;
		$display("Fail %0t o_emit_slot got %b expected %b", $time, o_emit_slot, exp_emit_slot);
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp) else begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// ----------------------------------------
	// CPU bus
	// ----------------------------------------
	task automatic bus_write(input access_width_e fmt, input logic [3:0] addr,
		input logic [31:0] data);
		@(posedge i_clk);
		i_cs      <= 1'b1;
		i_write   <= 1'b1;
		i_format  <= fmt;
		i_addr    <= addr;
		i_data_in <= data;
		@(posedge i_clk);
		i_cs    <= 1'b0;
		i_write <= 1'b0;
		@(negedge i_clk);
	endtask

	// Data is registered on the edge that samples the read
	task automatic bus_read(input access_width_e fmt, input logic [3:0] addr,
		output logic [31:0] data);
		@(posedge i_clk);
		i_cs     <= 1'b1;
		i_read   <= 1'b1;
		i_format <= fmt;
		i_addr   <= addr;
		@(posedge i_clk);
		i_cs   <= 1'b0;
		i_read <= 1'b0;
		@(negedge i_clk);
		data = o_data_out;
	endtask

	task automatic read_check(input string name, input logic [3:0] addr,
		input logic [31:0] exp);
		logic [31:0] rdata;
		bus_read(ACCESS_16BIT, addr, rdata);
		check_value(name, rdata, exp);
	endtask

	task automatic wait_tx_finished();
		logic [31:0] stat;
		int          polls;
		polls = 0;
		do begin
			bus_read(ACCESS_32BIT, {REG_STAT, 1'b0}, stat);
			polls++;
		end while (!stat[STAT_TX_FINISHED] && polls < POLL_LIMIT);
		if (!stat[STAT_TX_FINISHED]) begin
			$display("Timeout: transfer never reported finished at %0t", $time);
			$display("Errors found");
			$finish;
		end
	endtask

	task automatic wait_irq_high();
		int cycles;
		cycles = 0;
		while (!o_irq && cycles < IRQ_WAIT_LIMIT) begin
			@(negedge i_clk);
			cycles++;
		end
		if (!o_irq) begin
			$display("Timeout: interrupt request never rose at %0t", $time);
			$display("Errors found");
			$finish;
		end
	endtask

	// One byte out, reply left in the FIFO
	task automatic transfer_byte(input logic [7:0] data, input device_e dev);
		int emits_before;
		exp_emit_data <= data;
		exp_emit_dev  <= dev;
		emits_before = emit_count;
		bus_write(ACCESS_32BIT, {REG_TX_RX_DATA, 1'b0}, {24'd0, data});
		wait_tx_finished();
		check_value("emit count", emit_count, emits_before + 1);
	endtask

	task automatic drain_reply();
		logic [31:0] rdata;
		logic [7:0]  expected;
		assert (replies.size() != 0) else begin
			errors++;
			$display("Slot 0 read with no reply sent by the device at %0t", $time);
		end
		if (replies.size() != 0) begin
			expected = replies.pop_front();
			bus_read(ACCESS_32BIT, {REG_TX_RX_DATA, 1'b0}, rdata);
			check_value("slot 0 data", rdata, {24'd0, expected});
		end
	endtask

	task automatic send_byte(input logic [7:0] data, input device_e dev);
		logic [31:0] stat;
		transfer_byte(data, dev);
		drain_reply();
		bus_read(ACCESS_32BIT, {REG_STAT, 1'b0}, stat);
		check_value("STAT RX_PENDING", 32'(stat[STAT_RX_PENDING]), 32'd0);
	endtask

	// Idle register state, TX_READY only
	task automatic check_reset_state();
		logic [31:0] stat;
		bus_read(ACCESS_32BIT, {REG_STAT, 1'b0}, stat);
		check_value("STAT", stat, 32'd1 << STAT_TX_READY);
		read_check("MODE", {REG_MODE, 1'b0}, 32'd0);
		read_check("CTRL", {REG_CTRL, 1'b0}, 32'd0);
		read_check("BAUD", {REG_BAUD, 1'b0}, 32'd0);
		check_value("o_irq", 32'(o_irq), 32'd0);
		check_value("o_select", 32'(o_select), 32'd0);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		resetACK  = 1'b1;
		i_cs      = 1'b0;
		i_format  = ACCESS_8BIT;
		i_addr    = 4'd0;
		i_write   = 1'b0;
		i_read    = 1'b0;
		i_data_in = 32'd0;
		i_ack_n   = 1'b1;
		repeat (4) @(posedge i_clk);
		resetACK <= 1'b0;
		@(negedge i_clk);

		check_reset_state();

		// Readback through the masks
		bus_write(ACCESS_16BIT, {REG_MODE, 1'b0}, 32'h0000_FFFF);
		read_check("MODE", {REG_MODE, 1'b0}, {16'd0, 16'hFFFF & MODE_RW_MASK});
		// All bits except both commands
		bus_write(ACCESS_16BIT, {REG_CTRL, 1'b0}, 32'h0000_FFAF);
		read_check("CTRL", {REG_CTRL, 1'b0}, {16'd0, 16'hFFAF & CTRL_RW_MASK});
		check_value("o_select", 32'(o_select), 32'd1);
		bus_write(ACCESS_16BIT, {REG_CTRL, 1'b0}, 32'h0000_0000);
		check_value("o_select", 32'(o_select), 32'd0);
		bus_write(ACCESS_16BIT, {REG_BAUD, 1'b0}, 32'h0000_A5C3);
		read_check("BAUD", {REG_BAUD, 1'b0}, 32'h0000_A5C3);
		// Short baud period for the transfers
		bus_write(ACCESS_16BIT, {REG_MODE, 1'b0}, 32'h0000_0001);
		bus_write(ACCESS_16BIT, {REG_BAUD, 1'b0}, 32'h0000_0004);

		// Controller then memory card
		bus_write(ACCESS_16BIT, {REG_CTRL, 1'b0}, 32'h0000_0003);
		send_byte(SEL_CONTROLLER, DEV_NONE);
		send_byte(8'h5A, DEV_CONTROLLER);
		bus_write(ACCESS_16BIT, {REG_CTRL, 1'b0}, 32'h0000_0001);
		// Memory card behind the second slot
		bus_write(ACCESS_16BIT, {REG_CTRL, 1'b0}, 32'h0000_2003);
		exp_emit_slot <= 1'b1;
		send_byte(SEL_MEMCARD, DEV_NONE);
		send_byte(8'h42, DEV_MEMCARD);
		exp_emit_slot <= 1'b0;

		// RX interrupt at two entries
		bus_write(ACCESS_16BIT, {REG_CTRL, 1'b0}, 32'h0000_0001);
		bus_write(ACCESS_16BIT, {REG_CTRL, 1'b0}, 32'h0000_0903);
		transfer_byte(8'h33, DEV_NONE);
		check_value("o_irq", 32'(o_irq), 32'd0);
		transfer_byte(8'h34, DEV_NONE);
		wait_irq_high();
		drain_reply();
		drain_reply();
		bus_write(ACCESS_16BIT, {REG_CTRL, 1'b0}, 32'h0000_0913);
		check_value("o_irq", 32'(o_irq), 32'd0);
		// ACK line interrupt
		bus_write(ACCESS_16BIT, {REG_CTRL, 1'b0}, 32'h0000_1000);
		@(posedge i_clk);
		i_ack_n <= 1'b0;
		wait_irq_high();
		@(posedge i_clk);
		i_ack_n <= 1'b1;
		bus_write(ACCESS_16BIT, {REG_CTRL, 1'b0}, 32'h0000_1010);
		check_value("o_irq", 32'(o_irq), 32'd0);

		// Legal formats leave the flag alone
		bus_write(ACCESS_8BIT, 4'd0, 32'h0000_0012);
		read_check("MODE", {REG_MODE, 1'b0}, 32'h0000_0001);
		check_value("o_bad_access", 32'(o_bad_access), 32'd0);
		bus_write(ACCESS_8BIT, 4'd2, 32'h0000_0012);
		check_value("o_bad_access", 32'(o_bad_access), 32'd1);
		bus_write(ACCESS_16BIT, {REG_CTRL, 1'b0}, 32'h0000_0040);
		check_value("o_bad_access", 32'(o_bad_access), 32'd0);
		read_check("slot 3", 4'd6, 32'd0);
		check_value("o_bad_access", 32'(o_bad_access), 32'd1);

		// Setup reset with a byte left in the FIFO
		bus_write(ACCESS_16BIT, {REG_MODE, 1'b0}, 32'h0000_0001);
		bus_write(ACCESS_16BIT, {REG_BAUD, 1'b0}, 32'h0000_0004);
		bus_write(ACCESS_16BIT, {REG_CTRL, 1'b0}, 32'h0000_0003);
		transfer_byte(8'h77, DEV_NONE);
		bus_write(ACCESS_16BIT, {REG_CTRL, 1'b0}, 32'h0000_0040);
		replies.delete();
		check_reset_state();
		check_value("o_bad_access", 32'(o_bad_access), 32'd0);

		$display("Checks done, %0d errors", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/joy_reg_pkg.sv
hdl/joy_link_pkg.sv
hdl/joy_regs.sv
hdl/joy_baud_timer.sv
hdl/joy_xfer.sv
hdl/joy_rx_fifo.sv
hdl/joy_io_top.sv
tests/tb_joy_io.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench, pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_joy_io -f filelist.f -o tb_joy_io &&
./obj_dir/tb_joy_io | tee /dev/stderr | grep -q "No errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
